//--- src/isa_pkg.sv
// Instruction set definitions for the 32-bit core
// Data and register number widths
// Opcode and ALU function encodings
// Register, immediate and jump formats, and the union over them
package isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // Primary opcodes, bits 31:27
    localparam logic [4:0] op_alu  = 5'b00000;
    localparam logic [4:0] op_j    = 5'b00001;
    localparam logic [4:0] op_bne  = 5'b00010;
    localparam logic [4:0] op_addi = 5'b00101;
    localparam logic [4:0] op_blt  = 5'b00110;
    localparam logic [4:0] op_sw   = 5'b00111;
    localparam logic [4:0] op_lw   = 5'b01000;

    // ALU function field of R-type words, bits 6:2
    localparam logic [4:0] alu_add = 5'b00000;
    localparam logic [4:0] alu_sub = 5'b00001;
    localparam logic [4:0] alu_and = 5'b00010;
    localparam logic [4:0] alu_or  = 5'b00011;
    localparam logic [4:0] alu_sll = 5'b00100;
    localparam logic [4:0] alu_sra = 5'b00101;

    typedef struct packed {
        logic [4:0]            opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [4:0]            shamt;
        logic [4:0]            alu_fn;
        logic [1:0]            zero;
    } r_fmt_t;

    typedef struct packed {
        logic [4:0]            opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs;
        logic signed [16:0]    imm;
    } i_fmt_t;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [26:0] target;
    } j_fmt_t;

    // One fetched word, seen as any of the three formats
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } insn_t;

endpackage

//--- src/pipe_pkg.sv
// Pipeline definitions for the five-stage core
// Decoded control bundle
// Stage registers, writeback bundle and fetch redirect
package pipe_pkg;

    typedef struct packed {
        logic [4:0] alu_fn;
        logic       uses_imm;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        logic       is_bne;
        logic       is_blt;
        logic       is_jump;
    } ctrl_t;

    typedef struct packed {
        logic                      valid;
        logic [isa_pkg::xlen-1:0]  pc_plus1;
        isa_pkg::insn_t            instruction;
    } if_id_t;

    typedef struct packed {
        logic                            valid;
        ctrl_t                           ctrl;
        logic [isa_pkg::reg_addr_w-1:0]  rs_num;
        logic [isa_pkg::reg_addr_w-1:0]  rt_num;
        logic [isa_pkg::xlen-1:0]        a;
        logic [isa_pkg::xlen-1:0]        b;
        logic [isa_pkg::xlen-1:0]        imm;
        logic [isa_pkg::xlen-1:0]        target;
        logic [isa_pkg::reg_addr_w-1:0]  rd;
        logic [isa_pkg::xlen-1:0]        pc_plus1;
    } id_ex_t;

    typedef struct packed {
        logic                            valid;
        ctrl_t                           ctrl;
        logic [isa_pkg::xlen-1:0]        result;
        logic [isa_pkg::xlen-1:0]        store_data;
        logic [isa_pkg::reg_addr_w-1:0]  rd;
    } ex_mem_t;

    typedef struct packed {
        logic                            reg_write;
        logic [isa_pkg::reg_addr_w-1:0]  rd;
        logic [isa_pkg::xlen-1:0]        value;
    } wb_t;

    typedef struct packed {
        logic                      taken;
        logic [isa_pkg::xlen-1:0]  target;
    } redirect_t;

endpackage

//--- src/fetch_stage.sv
// Fetch stage
// Program counter with redirect and stall handling
// Fetch/decode pipeline register
module fetch_stage (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     stall,
    input  pipe_pkg::redirect_t      redirect,
    input  logic [isa_pkg::xlen-1:0] q_imem,
    output logic [isa_pkg::xlen-1:0] address_imem,
    output pipe_pkg::if_id_t         if_id
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus1;

    // Word addressed, so the next word is pc+1
    assign pc_plus1     = pc + 1'b1;
    assign address_imem = pc;

    always_ff @(posedge clock) begin
        // Payload follows the fetched word unless decode is holding
        if (!stall) begin
            if_id.pc_plus1    <= pc_plus1;
            if_id.instruction <= q_imem;
        end
        if (!rst_n) begin
            pc          <= '0;
            if_id.valid <= 1'b0;
        end else if (redirect.taken) begin
            // Redirect beats stall, word in flight becomes a bubble
            pc          <= redirect.target;
            if_id.valid <= 1'b0;
        end else if (!stall) begin
            pc          <= pc_plus1;
            if_id.valid <= 1'b1;
        end
    end

    // Stall only comes from a load in execute, which never redirects
    a_no_stall_on_redirect: assert property (@(posedge clock) disable iff (!rst_n)
        !(stall && redirect.taken));

endmodule

//--- src/decode_stage.sv
// Decode stage
// Field decode and control bundle, register read port selection
// Writeback bypass, immediate sign extension, load-use stall
// Decode/execute pipeline register
module decode_stage (
    input  logic                           clock,
    input  logic                           rst_n,
    input  pipe_pkg::if_id_t               if_id,
    input  pipe_pkg::redirect_t            redirect,
    input  logic [isa_pkg::reg_addr_w-1:0] ex_load_rd,
    input  pipe_pkg::wb_t                  wb,
    input  logic [isa_pkg::xlen-1:0]       data_read_reg_a,
    input  logic [isa_pkg::xlen-1:0]       data_read_reg_b,
    output logic [isa_pkg::reg_addr_w-1:0] ctrl_read_reg_a,
    output logic [isa_pkg::reg_addr_w-1:0] ctrl_read_reg_b,
    output logic                           stall,
    output pipe_pkg::id_ex_t               id_ex
);
    import isa_pkg::*;
    import pipe_pkg::*;

    insn_t  insn;
    logic   is_alu;
    logic   is_addi;
    logic   is_lw;
    logic   is_sw;
    logic   is_bne;
    logic   is_blt;
    logic   is_j;
    logic   uses_a;
    logic   uses_b;
    ctrl_t  ctrl;
    id_ex_t id_ex_next;

    assign insn    = if_id.instruction;
    assign is_alu  = insn.r.opcode == op_alu;
    assign is_addi = insn.i.opcode == op_addi;
    assign is_lw   = insn.i.opcode == op_lw;
    assign is_sw   = insn.i.opcode == op_sw;
    assign is_bne  = insn.i.opcode == op_bne;
    assign is_blt  = insn.i.opcode == op_blt;
    assign is_j    = insn.j.opcode == op_j;

    // Branches compare $rd with $rs, sw stores $rd from port B
    assign ctrl_read_reg_a = (is_bne || is_blt) ? insn.i.rd : insn.i.rs;
    assign ctrl_read_reg_b = is_sw ? insn.i.rd :
                             (is_bne || is_blt) ? insn.i.rs : insn.r.rt;

    // Which ports carry a real operand, j reads nothing
    assign uses_a = is_alu || is_addi || is_lw || is_sw || is_bne || is_blt;
    assign uses_b = is_alu || is_sw || is_bne || is_blt;

    always_comb begin
        ctrl           = '0;
        // Non-ALU opcodes all add, for addresses and addi
        ctrl.alu_fn    = is_alu ? insn.r.alu_fn : alu_add;
        ctrl.uses_imm  = is_addi || is_lw || is_sw;
        ctrl.mem_read  = is_lw;
        ctrl.mem_write = is_sw;
        // Writes to r0 dropped here
        ctrl.reg_write = (is_alu || is_addi || is_lw) && (insn.i.rd != '0);
        ctrl.is_bne    = is_bne;
        ctrl.is_blt    = is_blt;
        ctrl.is_jump   = is_j;
        if (!if_id.valid) begin
            ctrl = '0;
        end
    end

    // Load in execute feeding this instruction, hold one cycle
    assign stall = if_id.valid && (ex_load_rd != '0) &&
                   ((uses_a && ex_load_rd == ctrl_read_reg_a) ||
                    (uses_b && ex_load_rd == ctrl_read_reg_b));

    always_comb begin
        id_ex_next          = '0;
        id_ex_next.valid    = if_id.valid;
        id_ex_next.ctrl     = ctrl;
        id_ex_next.rs_num   = ctrl_read_reg_a;
        id_ex_next.rt_num   = ctrl_read_reg_b;
        // Bypass the write landing at the end of this cycle
        id_ex_next.a        = (wb.reg_write && wb.rd == ctrl_read_reg_a) ?
                              wb.value : data_read_reg_a;
        id_ex_next.b        = (wb.reg_write && wb.rd == ctrl_read_reg_b) ?
                              wb.value : data_read_reg_b;
        id_ex_next.imm      = {{(xlen-17){insn.i.imm[16]}}, insn.i.imm};
        id_ex_next.target   = {{(xlen-27){1'b0}}, insn.j.target};
        id_ex_next.rd       = insn.i.rd;
        id_ex_next.pc_plus1 = if_id.pc_plus1;
    end

    always_ff @(posedge clock) begin
        id_ex <= id_ex_next;
        // Bubble on stall or flush
        if (!rst_n || stall || redirect.taken) begin
            id_ex.valid <= 1'b0;
            id_ex.ctrl  <= '0;
        end
    end

    // Register file never sees a write to r0
    a_no_r0_write: assert property (@(posedge clock) disable iff (!rst_n)
        wb.reg_write |-> wb.rd != '0);

endmodule

//--- src/execute_stage.sv
// Execute stage
// Operand forwarding from memory and writeback
// ALU, branch compare, branch and jump redirect
// Execute/memory pipeline register
module execute_stage (
    input  logic                           clock,
    input  logic                           rst_n,
    input  pipe_pkg::id_ex_t               id_ex,
    input  pipe_pkg::wb_t                  wb,
    output pipe_pkg::redirect_t            redirect,
    output logic [isa_pkg::reg_addr_w-1:0] ex_load_rd,
    output pipe_pkg::ex_mem_t              ex_mem
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [xlen-1:0] fwd_a;
    logic [xlen-1:0] fwd_b;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] alu_result;
    logic            mem_hit_a;
    logic            mem_hit_b;
    logic            bne_taken;
    logic            blt_taken;

    // Memory stage result is ready unless it is a load address
    assign mem_hit_a = ex_mem.valid && ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_read &&
                       (ex_mem.rd == id_ex.rs_num);
    assign mem_hit_b = ex_mem.valid && ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_read &&
                       (ex_mem.rd == id_ex.rt_num);

    // Younger producer wins
    assign fwd_a = mem_hit_a ? ex_mem.result :
                   (wb.reg_write && wb.rd == id_ex.rs_num) ? wb.value : id_ex.a;
    assign fwd_b = mem_hit_b ? ex_mem.result :
                   (wb.reg_write && wb.rd == id_ex.rt_num) ? wb.value : id_ex.b;

    assign op_b = id_ex.ctrl.uses_imm ? id_ex.imm : fwd_b;

    // Shift amount of an R-type word sits in immediate bits 11:7
    assign shamt = id_ex.imm[11:7];

    always_comb begin
        case (id_ex.ctrl.alu_fn)
            alu_add: alu_result = fwd_a + op_b;
            alu_sub: alu_result = fwd_a - op_b;
            alu_and: alu_result = fwd_a & op_b;
            alu_or:  alu_result = fwd_a | op_b;
            alu_sll: alu_result = fwd_a << shamt;
            alu_sra: alu_result = $signed(fwd_a) >>> shamt;
            default: alu_result = '0;
        endcase
    end

    // a holds $rd and b holds $rs for branches
    assign bne_taken = id_ex.ctrl.is_bne && (fwd_a != fwd_b);
    assign blt_taken = id_ex.ctrl.is_blt && ($signed(fwd_a) < $signed(fwd_b));

    assign redirect.taken  = id_ex.valid && (id_ex.ctrl.is_jump || bne_taken || blt_taken);
    assign redirect.target = id_ex.ctrl.is_jump ? id_ex.target : id_ex.pc_plus1 + id_ex.imm;

    // Destination of a load, for the decode stall check
    assign ex_load_rd = (id_ex.valid && id_ex.ctrl.mem_read) ? id_ex.rd : '0;

    always_ff @(posedge clock) begin
        ex_mem.result     <= alu_result;
        // Store data is the forwarded $rd value
        ex_mem.store_data <= fwd_b;
        ex_mem.rd         <= id_ex.rd;
        if (!rst_n) begin
            ex_mem.valid <= 1'b0;
            ex_mem.ctrl  <= '0;
        end else begin
            ex_mem.valid <= id_ex.valid;
            ex_mem.ctrl  <= id_ex.ctrl;
        end
    end

    // Both younger slots reach execute as bubbles after a redirect
    a_redirect_flush: assert property (@(posedge clock) disable iff (!rst_n)
        redirect.taken |=> !id_ex.valid ##1 !id_ex.valid);

endmodule

//--- src/memory_stage.sv
// Memory stage
// Data memory address, store data and write enable
// Load or ALU result select and writeback register
module memory_stage (
    input  logic                     clock,
    input  logic                     rst_n,
    input  pipe_pkg::ex_mem_t        ex_mem,
    input  logic [isa_pkg::xlen-1:0] q_dmem,
    output logic [isa_pkg::xlen-1:0] address_dmem,
    output logic [isa_pkg::xlen-1:0] data,
    output logic                     wren,
    output pipe_pkg::wb_t            wb
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [xlen-1:0] value;

    // ALU result is the word address for lw and sw
    assign address_dmem = ex_mem.result;
    assign data         = ex_mem.store_data;
    assign wren         = ex_mem.valid && ex_mem.ctrl.mem_write;

    // Load data arrives in the same cycle
    assign value = ex_mem.ctrl.mem_read ? q_dmem : ex_mem.result;

    always_ff @(posedge clock) begin
        wb.rd    <= ex_mem.rd;
        wb.value <= value;
        if (!rst_n) begin
            wb.reg_write <= 1'b0;
        end else begin
            wb.reg_write <= ex_mem.valid && ex_mem.ctrl.reg_write;
        end
    end

    // A store never leaves a register write behind it
    a_store_no_wb: assert property (@(posedge clock) disable iff (!rst_n)
        wren |=> !wb.reg_write);

endmodule

//--- src/processor.sv
// Five-stage pipelined core, top level
// Fetch, decode, execute and memory stages in a chain
// Instruction memory, data memory and register file ports
module processor (
    input  logic                           clock,
    input  logic                           rst_n,
    output logic [isa_pkg::xlen-1:0]       address_imem,
    input  logic [isa_pkg::xlen-1:0]       q_imem,
    output logic [isa_pkg::xlen-1:0]       address_dmem,
    output logic [isa_pkg::xlen-1:0]       data,
    output logic                           wren,
    input  logic [isa_pkg::xlen-1:0]       q_dmem,
    output logic                           ctrl_write_enable,
    output logic [isa_pkg::reg_addr_w-1:0] ctrl_write_reg,
    output logic [isa_pkg::reg_addr_w-1:0] ctrl_read_reg_a,
    output logic [isa_pkg::reg_addr_w-1:0] ctrl_read_reg_b,
    output logic [isa_pkg::xlen-1:0]       data_write_reg,
    input  logic [isa_pkg::xlen-1:0]       data_read_reg_a,
    input  logic [isa_pkg::xlen-1:0]       data_read_reg_b
);
    import isa_pkg::*;
    import pipe_pkg::*;

    if_id_t                if_id;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    wb_t                   wb;
    redirect_t             redirect;
    logic                  stall;
    logic [reg_addr_w-1:0] ex_load_rd;

    fetch_stage fetch_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .stall        (stall),
        .redirect     (redirect),
        .q_imem       (q_imem),
        .address_imem (address_imem),
        .if_id        (if_id)
    );

    decode_stage decode_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .if_id           (if_id),
        .redirect        (redirect),
        .ex_load_rd      (ex_load_rd),
        .wb              (wb),
        .data_read_reg_a (data_read_reg_a),
        .data_read_reg_b (data_read_reg_b),
        .ctrl_read_reg_a (ctrl_read_reg_a),
        .ctrl_read_reg_b (ctrl_read_reg_b),
        .stall           (stall),
        .id_ex           (id_ex)
    );

    execute_stage execute_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .id_ex      (id_ex),
        .wb         (wb),
        .redirect   (redirect),
        .ex_load_rd (ex_load_rd),
        .ex_mem     (ex_mem)
    );

    memory_stage memory_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .ex_mem       (ex_mem),
        .q_dmem       (q_dmem),
        .address_dmem (address_dmem),
        .data         (data),
        .wren         (wren),
        .wb           (wb)
    );

    // Writeback register drives the register file write port
    assign ctrl_write_enable = wb.reg_write;
    assign ctrl_write_reg    = wb.rd;
    assign data_write_reg    = wb.value;

endmodule

//--- testbench/tb_processor.sv
// Testbench for the five-stage core
// Clock, reset, and combinational memory and register file models
// Program and expected write traces loaded from a pattern file
// Register and data memory writes checked in program order
module tb_processor;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int pattern_words  = 192;
    localparam int timeout_cycles = 2000;
    // Edges after reset release before the first write may show
    localparam int quiet_cycles   = 4;
    localparam int drain_cycles   = 10;

    typedef struct packed {
        logic [31:0] where;
        logic [31:0] value;
    } write_t;

    logic        clock;
    logic        rst_n;
    logic [31:0] address_imem;
    logic [31:0] q_imem;
    logic [31:0] address_dmem;
    logic [31:0] data;
    logic        wren;
    logic [31:0] q_dmem;
    logic        ctrl_write_enable;
    logic [4:0]  ctrl_write_reg;
    logic [4:0]  ctrl_read_reg_a;
    logic [4:0]  ctrl_read_reg_b;
    logic [31:0] data_write_reg;
    logic [31:0] data_read_reg_a;
    logic [31:0] data_read_reg_b;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] regs [0:31];
    logic [31:0] pattern_mem [0:pattern_words-1];
    write_t      reg_exp [$];
    write_t      mem_exp [$];
    int          edges = 0;
    int          run_cycles = 0;
    int          reg_count = 0;
    int          mem_count = 0;

    processor processor_i (
        .clock             (clock),
        .rst_n             (rst_n),
        .address_imem      (address_imem),
        .q_imem            (q_imem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .q_dmem            (q_dmem),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .ctrl_read_reg_a   (ctrl_read_reg_a),
        .ctrl_read_reg_b   (ctrl_read_reg_b),
        .data_write_reg    (data_write_reg),
        .data_read_reg_a   (data_read_reg_a),
        .data_read_reg_b   (data_read_reg_b)
    );

    // Memories and register file answer in the same cycle
    assign q_imem          = imem[address_imem[7:0]];
    assign q_dmem          = dmem[address_dmem[7:0]];
    // r0 always reads as zero
    assign data_read_reg_a = (ctrl_read_reg_a == 5'd0) ? 32'd0 : regs[ctrl_read_reg_a];
    assign data_read_reg_b = (ctrl_read_reg_b == 5'd0) ? 32'd0 : regs[ctrl_read_reg_b];

    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // Tag 1 fills instruction memory, tags 2 and 3 queue expected writes
    task automatic load_patterns();
        int     n;
        write_t entry;
        for (n = 0; n < 256; n++) begin
            imem[n] = 32'd0;
            dmem[n] <= 32'd0;
        end
        for (n = 0; n < 32; n++) begin
            regs[n] <= 32'd0;
        end
        for (n = 0; n < pattern_words; n++) begin
            pattern_mem[n] = 32'd0;
        end
        $readmemh("testbench/processor_patterns.txt", pattern_mem);
        for (n = 0; n + 2 < pattern_words; n += 3) begin
            entry.where = pattern_mem[n+1];
            entry.value = pattern_mem[n+2];
            case (pattern_mem[n])
                32'd0: ;
                32'd1: imem[entry.where[7:0]] = entry.value;
                32'd2: reg_exp.push_back(entry);
                32'd3: mem_exp.push_back(entry);
                default: abort_run($sformatf("unknown tag %0h in the pattern file", pattern_mem[n]));
            endcase
        end
    endtask

    // Trace monitor samples outputs before the edge updates them
    always @(posedge clock) begin
        write_t expected;
        edges = edges + 1;
        if ((!rst_n && edges > 1) || (rst_n && run_cycles < quiet_cycles)) begin
            check_value("no writes around reset", 32'd0, {30'd0, wren, ctrl_write_enable});
        end
        if (ctrl_write_enable) begin
            if (reg_exp.size() == 0) begin
                abort_run("register write seen after the expected trace was used up");
            end else begin
                expected = reg_exp.pop_front();
                check_value($sformatf("register write %0d number", reg_count),
                            expected.where, {27'd0, ctrl_write_reg});
                check_value($sformatf("register write %0d value", reg_count),
                            expected.value, data_write_reg);
                reg_count++;
                if (ctrl_write_reg != 5'd0) begin
                    regs[ctrl_write_reg] <= data_write_reg;
                end
            end
        end
        if (wren) begin
            if (mem_exp.size() == 0) begin
                abort_run("memory write seen after the expected trace was used up");
            end else begin
                expected = mem_exp.pop_front();
                check_value($sformatf("memory write %0d address", mem_count),
                            expected.where, address_dmem);
                check_value($sformatf("memory write %0d value", mem_count),
                            expected.value, data);
                mem_count++;
                dmem[address_dmem[7:0]] <= data;
            end
        end
        if (rst_n) begin
            run_cycles = run_cycles + 1;
        end
    end

    initial begin
        int waited;
        rst_n = 1'b0;
        load_patterns();
        repeat (10) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        waited = 0;
        while ((reg_exp.size() != 0 || mem_exp.size() != 0) && waited < timeout_cycles) begin
            @(negedge clock);
            waited++;
        end
        if (reg_exp.size() != 0 || mem_exp.size() != 0) begin
            abort_run($sformatf("timeout, %0d register and %0d memory writes never arrived",
                                reg_exp.size(), mem_exp.size()));
        end else begin
            // Spinning jump loop must stay silent
            repeat (drain_cycles) @(negedge clock);
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- testbench/processor_patterns.txt
// Columns: tag, address or register, value (hex)
// Tag 1 program word, tag 2 register write, tag 3 data memory write
1 00 28400005  // addi r1, r0, 5
1 01 2881FFFD  // addi r2, r0, -3
1 02 00C22000  // add  r3, r1, r2
1 03 01061004  // sub  r4, r3, r1
1 04 01481008  // and  r5, r4, r1
1 05 018A200C  // or   r6, r5, r2
1 06 01C20210  // sll  r7, r1, 4
1 07 02040094  // sra  r8, r2, 1
1 08 39C0000A  // sw   r7, 10(r0)
1 09 2A4E0001  // addi r9, r7, 1
1 0A 3A40000B  // sw   r9, 11(r0)
1 0B 4280000A  // lw   r10, 10(r0)
1 0C 02D41000  // add  r11, r10, r1 after load
1 0D 4300000B  // lw   r12, 11(r0)
1 0E 3B02000C  // sw   r12, 12(r1) after load
1 0F 10420005  // bne  r1, r1, +5 not taken
1 10 30820002  // blt  r2, r1, +2 taken
1 11 2B400063  // addi r13, r0, 99 flushed
1 12 2B400062  // addi r13, r0, 98 skipped
1 13 30440003  // blt  r1, r2, +3 not taken
1 14 10440001  // bne  r1, r2, +1 taken
1 15 2B80004D  // addi r14, r0, 77 flushed
1 16 2BC00123  // addi r15, r0, 0x123
1 17 0800001A  // j    26
1 18 2C000001  // addi r16, r0, 1 flushed
1 19 2C400002  // addi r17, r0, 2 flushed
1 1A 3BC00014  // sw   r15, 20(r0)
1 1B 00021000  // add  r0, r1, r1 no write
1 1C 0480F000  // add  r18, r0, r15
1 1D 0800001D  // j    29 spin
2 01 00000005
2 02 FFFFFFFD
2 03 00000002
2 04 FFFFFFFD
2 05 00000005
2 06 FFFFFFFD
2 07 00000050
2 08 FFFFFFFE
2 09 00000051
2 0A 00000050
2 0B 00000055
2 0C 00000051
2 0F 00000123
2 12 00000123
3 0A 00000050
3 0B 00000051
3 11 00000051
3 14 00000123

//--- compile.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/processor.sv
testbench/tb_processor.sv

//--- Makefile
BUILD := build
LOG   := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f compile.f \
		--top-module tb_processor --Mdir $(BUILD) -o tb_processor
	$(BUILD)/tb_processor | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
